// File: verilog/core_pkg.sv
package core_pkg;

	typedef logic [7:0] data_t;
	typedef logic [3:0] reg_idx_t;

	localparam int NUM_REGS = 16;

	// Top nibble of the instruction word
	localparam logic [3:0] CLASS_IMM = 4'b0100;
	localparam logic [3:0] CLASS_RR = 4'b0101;
	localparam logic [7:0] EXT_PREFIX = 8'b0101_1111; // Overlaps CLASS_RR, checked first

	// Register-register opcodes 0..11 write R1, 14 only sets flags
	localparam logic [3:0] RR_ALU_MAX = 4'd11;
	localparam logic [3:0] RR_CMP = 4'd14;

	localparam logic [3:0] EXT_RSH = 4'd0;
	localparam logic [3:0] EXT_RSHC = 4'd1;
	localparam logic [3:0] EXT_LSH = 4'd2;
	localparam logic [3:0] EXT_LSHC = 4'd3;
	localparam logic [3:0] EXT_ROR = 4'd4;
	localparam logic [3:0] EXT_ROL = 4'd5;
	localparam logic [3:0] EXT_CMPI = 4'd9;

	typedef struct packed {
		logic [3:0] cls;
		logic [3:0] opc;
		reg_idx_t r1;
		logic [3:0] r2; // Second register or immediate nibble
	} rr_t;

	typedef struct packed {
		logic [3:0] cls;
		reg_idx_t rd;
		data_t val;
	} imm_t;

	typedef struct packed {
		logic [7:0] prefix;
		logic [3:0] opc;
		reg_idx_t rg;
	} ext_t;

	typedef union packed {
		rr_t rr_view;
		imm_t imm_view;
		ext_t ext_view;
	} instr_u;

endpackage

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst_n,
	input core_pkg::reg_idx_t rd_a_idx,
	output core_pkg::data_t rd_a,
	input core_pkg::reg_idx_t rd_b_idx,
	output core_pkg::data_t rd_b,
	input logic wr_en,
	input core_pkg::reg_idx_t wr_idx,
	input core_pkg::data_t wr_data
);

	core_pkg::data_t regs [core_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data; // R0 stays zero
		end
	end

	// Asynchronous read so the stage sees last cycle's writeback
	assign rd_a = regs[rd_a_idx];
	assign rd_b = regs[rd_b_idx];

	// R0 must never be observed nonzero, even right after a write aimed at it
	a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_a_idx == '0 |-> rd_a == '0) and (rd_b_idx == '0 |-> rd_b == '0));

endmodule

// File: verilog/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input core_pkg::instr_u in_instr,
	input logic advance,
	output logic stage_valid,
	output core_pkg::instr_u stage_instr
);

	logic load;

	// Free slot, or the held instruction leaves this edge
	assign in_ready = !stage_valid || advance;
	assign load = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_valid <= 1'b0;
		end else if (load) begin
			stage_valid <= 1'b1;
		end else if (advance) begin
			stage_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			stage_instr <= in_instr;
		end
	end

	// Writeback stalls must leave the held instruction untouched
	a_stage_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stage_valid && !advance |=> stage_valid && $stable(stage_instr));

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
	input core_pkg::instr_u instr,
	input core_pkg::data_t op_a,
	input core_pkg::data_t op_b,
	input logic c_in,
	output core_pkg::data_t alu_data,
	output logic alu_c,
	output logic alu_z
);

	logic [3:0] nib;
	logic [8:0] res; // Carry in bit 8
	logic is_cmp;

	assign nib = instr.rr_view.r2;
	assign is_cmp = instr.rr_view.opc == core_pkg::RR_CMP;

	always_comb begin
		case (instr.rr_view.opc)
			4'd0: res = {1'b0, op_a} + {1'b0, op_b};
			4'd1: res = {1'b0, op_a} + {1'b0, op_b} + {8'h00, c_in};
			4'd2: res = {1'b0, op_a} + {1'b0, ~op_b} + 9'd1;
			4'd3: res = {1'b0, op_a} + {1'b0, ~op_b} + {8'h00, c_in};
			4'd4: res = {c_in, op_a & op_b};
			4'd5: res = {c_in, op_a | op_b};
			4'd6: res = {c_in, op_a ^ op_b};
			4'd7: res = {c_in, ~op_b};
			4'd8: res = {1'b0, op_a} + {5'h00, nib};
			4'd9: res = {1'b0, op_a} + {5'h00, nib} + {8'h00, c_in};
			4'd10: res = {1'b0, op_a} + {5'h0f, ~nib} + 9'd1; // Nibble subtract
			4'd11: res = {1'b0, op_a} + {5'h0f, ~nib} + {8'h00, c_in};
			core_pkg::RR_CMP: res = {op_a >= op_b, op_a};
			default: res = {c_in, op_a};
		endcase
	end

	assign alu_data = res[7:0];
	assign alu_c = res[8];
	assign alu_z = is_cmp ? (op_a == op_b) : (res[7:0] == 8'h00);

endmodule

// File: verilog/shift_unit.sv
`timescale 1ns/1ps

module shift_unit (
	input core_pkg::instr_u instr,
	input core_pkg::data_t op_a,
	input core_pkg::data_t op_r1,
	input logic c_in,
	output core_pkg::data_t sh_data,
	output logic sh_c,
	output logic sh_z
);

	logic [3:0] opc;
	logic fill; // Bit shifted in, carry only for the odd opcodes
	core_pkg::data_t nib_ext;

	assign opc = instr.ext_view.opc;
	assign fill = c_in & opc[0];
	assign nib_ext = {4'h0, instr.ext_view.rg};

	always_comb begin
		sh_data = op_a;
		sh_c = c_in;
		case (opc)
			core_pkg::EXT_RSH, core_pkg::EXT_RSHC: begin
				sh_data = {fill, op_a[7:1]};
				sh_c = op_a[0];
			end
			core_pkg::EXT_LSH, core_pkg::EXT_LSHC: begin
				sh_data = {op_a[6:0], fill};
				sh_c = op_a[7];
			end
			core_pkg::EXT_ROR: sh_data = {op_a[0], op_a[7:1]};
			core_pkg::EXT_ROL: sh_data = {op_a[6:0], op_a[7]};
			core_pkg::EXT_CMPI: begin
				sh_data = op_r1;
				sh_c = op_r1 >= nib_ext;
			end
			default: ;
		endcase
	end

	// Compare reports equality, everything else reports a zero result
	assign sh_z = (opc == core_pkg::EXT_CMPI) ? (op_r1 == nib_ext) : (sh_data == 8'h00);

endmodule

// File: verilog/writeback.sv
`timescale 1ns/1ps

module writeback (
	input logic clk,
	input logic rst_n,
	input logic stage_valid,
	input core_pkg::instr_u stage_instr,
	output logic advance,
	input core_pkg::data_t alu_data,
	input logic alu_c,
	input logic alu_z,
	input core_pkg::data_t sh_data,
	input logic sh_c,
	input logic sh_z,
	output logic imm_c_hold,
	input logic res_ready,
	output logic res_valid,
	output logic res_write,
	output core_pkg::reg_idx_t res_reg,
	output core_pkg::data_t res_data,
	output logic res_c,
	output logic res_z,
	output logic wr_en,
	output core_pkg::reg_idx_t wr_idx,
	output core_pkg::data_t wr_data
);

	logic is_imm;
	logic is_ext;
	logic is_rr;
	logic nxt_write;
	logic nxt_flags;
	core_pkg::reg_idx_t nxt_reg;
	core_pkg::data_t nxt_data;
	logic nxt_c;
	logic nxt_z;
	logic c_flag;
	logic z_flag;

	assign is_imm = stage_instr.imm_view.cls == core_pkg::CLASS_IMM;
	assign is_ext = stage_instr.ext_view.prefix == core_pkg::EXT_PREFIX;
	assign is_rr = stage_instr.rr_view.cls == core_pkg::CLASS_RR && !is_ext;

	always_comb begin
		nxt_write = 1'b0;
		nxt_flags = 1'b0;
		nxt_reg = stage_instr.rr_view.r1;
		nxt_data = alu_data;
		nxt_c = alu_c;
		nxt_z = alu_z;
		if (is_imm) begin
			nxt_write = 1'b1; // Flags untouched
			nxt_reg = stage_instr.imm_view.rd;
			nxt_data = stage_instr.imm_view.val;
		end else if (is_ext) begin
			nxt_reg = stage_instr.ext_view.rg;
			nxt_data = sh_data;
			nxt_c = sh_c;
			nxt_z = sh_z;
			nxt_write = stage_instr.ext_view.opc <= core_pkg::EXT_ROL;
			nxt_flags = nxt_write || stage_instr.ext_view.opc == core_pkg::EXT_CMPI;
		end else if (is_rr) begin
			nxt_write = stage_instr.rr_view.opc <= core_pkg::RR_ALU_MAX;
			nxt_flags = nxt_write || stage_instr.rr_view.opc == core_pkg::RR_CMP;
		end
	end

	// Retire when the output register is empty or drains this edge
	assign advance = stage_valid && (!res_valid || res_ready);

	assign wr_en = advance && nxt_write;
	assign wr_idx = nxt_reg;
	assign wr_data = nxt_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			c_flag <= 1'b0;
			z_flag <= 1'b0;
		end else if (advance) begin
			res_valid <= 1'b1;
			if (nxt_flags) begin
				c_flag <= nxt_c;
				z_flag <= nxt_z;
			end
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			res_write <= nxt_write;
			res_reg <= nxt_reg;
			res_data <= nxt_data;
		end
	end

	// Flags only move on advance, so they double as the reported flags
	assign res_c = c_flag;
	assign res_z = z_flag;
	assign imm_c_hold = c_flag;

	a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid
			&& $stable({res_write, res_reg, res_data, res_c, res_z}));

endmodule

// File: verilog/exec_top.sv
`timescale 1ns/1ps

module exec_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input core_pkg::instr_u in_instr,
	input logic res_ready,
	output logic res_valid,
	output logic res_write,
	output core_pkg::reg_idx_t res_reg,
	output core_pkg::data_t res_data,
	output logic res_c,
	output logic res_z
);

	logic stage_valid;
	core_pkg::instr_u stage_instr;
	logic advance;
	core_pkg::reg_idx_t rd_a_idx;
	core_pkg::data_t rd_a;
	core_pkg::data_t rd_b;
	core_pkg::data_t alu_data;
	logic alu_c;
	logic alu_z;
	core_pkg::data_t sh_data;
	logic sh_c;
	logic sh_z;
	logic c_flag;
	logic wr_en;
	core_pkg::reg_idx_t wr_idx;
	core_pkg::data_t wr_data;

	// EXT needs R1 on port A for the immediate compare, its own register on port B
	assign rd_a_idx = (stage_instr.ext_view.prefix == core_pkg::EXT_PREFIX) ? 4'd1
		: stage_instr.rr_view.r1;

	issue_stage issue_stage_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.advance(advance),
		.stage_valid(stage_valid),
		.stage_instr(stage_instr)
	);

	reg_file reg_file_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rd_a_idx(rd_a_idx),
		.rd_a(rd_a),
		.rd_b_idx(stage_instr.rr_view.r2),
		.rd_b(rd_b),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data)
	);

	alu_unit alu_unit_inst (
		.instr(stage_instr),
		.op_a(rd_a),
		.op_b(rd_b),
		.c_in(c_flag),
		.alu_data(alu_data),
		.alu_c(alu_c),
		.alu_z(alu_z)
	);

	shift_unit shift_unit_inst (
		.instr(stage_instr),
		.op_a(rd_b),
		.op_r1(rd_a),
		.c_in(c_flag),
		.sh_data(sh_data),
		.sh_c(sh_c),
		.sh_z(sh_z)
	);

	writeback writeback_inst (
		.clk(clk),
		.rst_n(rst_n),
		.stage_valid(stage_valid),
		.stage_instr(stage_instr),
		.advance(advance),
		.alu_data(alu_data),
		.alu_c(alu_c),
		.alu_z(alu_z),
		.sh_data(sh_data),
		.sh_c(sh_c),
		.sh_z(sh_z),
		.imm_c_hold(c_flag),
		.res_ready(res_ready),
		.res_valid(res_valid),
		.res_write(res_write),
		.res_reg(res_reg),
		.res_data(res_data),
		.res_c(res_c),
		.res_z(res_z),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data)
	);

endmodule

// File: sim/tb_exec.sv
`timescale 1ns/1ps

module tb_exec;

	typedef struct packed {
		logic [15:0] word;
		core_pkg::reg_idx_t rg;
		core_pkg::data_t data;
		logic [2:0] wcz; // Expected res_write, res_c, res_z
	} row_t;

	localparam int RST_CYCLES = 8;
	localparam int ROW_CYCLES = 20;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	core_pkg::instr_u in_instr;
	logic res_ready = 1'b0;
	logic res_valid;
	logic res_write;
	core_pkg::reg_idx_t res_reg;
	core_pkg::data_t res_data;
	logic res_c;
	logic res_z;

	row_t tbl[$];
	int out_idx = 0;
	int cycles = 0;
	int limit;
	logic stalled = 1'b0;
	logic hold_write;
	core_pkg::reg_idx_t hold_reg;
	core_pkg::data_t hold_data;
	logic hold_c;
	logic hold_z;

	exec_top exec_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_instr(in_instr),
		.res_ready(res_ready),
		.res_valid(res_valid),
		.res_write(res_write),
		.res_reg(res_reg),
		.res_data(res_data),
		.res_c(res_c),
		.res_z(res_z)
	);

	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_data(input core_pkg::data_t got, input core_pkg::data_t exp,
		input string what);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_reg(input core_pkg::reg_idx_t got, input core_pkg::reg_idx_t exp,
		input string what);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s is R%0d, expected R%0d", $time, what, got, exp));
		end
	endtask

	task automatic check_flag(input bit got, input bit exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_result(input row_t exp, input int idx);
		check_flag(res_write, exp.wcz[2], $sformatf("row %0d res_write", idx));
		check_reg(res_reg, exp.rg, $sformatf("row %0d res_reg", idx));
		check_data(res_data, exp.data, $sformatf("row %0d res_data", idx));
		check_flag(res_c, exp.wcz[1], $sformatf("row %0d res_c", idx));
		check_flag(res_z, exp.wcz[0], $sformatf("row %0d res_z", idx));
	endtask

	task automatic add_row(input logic [15:0] word, input core_pkg::reg_idx_t rg,
		input core_pkg::data_t data, input logic [2:0] wcz);
		row_t r;
		r = '{word, rg, data, wcz};
		tbl.push_back(r);
	endtask

	task automatic build_table();
		add_row(16'h413C, 4'h1, 8'h3C, 3'b100); // Load R1
		add_row(16'h42C4, 4'h2, 8'hC4, 3'b100);
		add_row(16'h4077, 4'h0, 8'h77, 3'b100); // Load into R0 is dropped
		add_row(16'h5010, 4'h1, 8'h3C, 3'b100); // R1 + R0
		add_row(16'h5012, 4'h1, 8'h00, 3'b111);
		add_row(16'h43FF, 4'h3, 8'hFF, 3'b111); // Flags untouched by load
		add_row(16'h5132, 4'h3, 8'hC4, 3'b110);
		add_row(16'h5110, 4'h1, 8'h01, 3'b100); // Carry ripples in
		add_row(16'h5223, 4'h2, 8'h00, 3'b111);
		add_row(16'h5313, 4'h1, 8'h3D, 3'b100);
		add_row(16'h44F0, 4'h4, 8'hF0, 3'b100);
		add_row(16'h5443, 4'h4, 8'hC0, 3'b100);
		add_row(16'h5524, 4'h2, 8'hC0, 3'b100);
		add_row(16'h5624, 4'h2, 8'h00, 3'b101);
		add_row(16'h5753, 4'h5, 8'h3B, 3'b100);
		add_row(16'h46FE, 4'h6, 8'hFE, 3'b100);
		add_row(16'h5863, 4'h6, 8'h01, 3'b110); // Nibble add wraps
		add_row(16'h596E, 4'h6, 8'h10, 3'b100);
		add_row(16'h5A61, 4'h6, 8'h0F, 3'b110);
		add_row(16'h5B6F, 4'h6, 8'h00, 3'b111);
		add_row(16'h5A61, 4'h6, 8'hFF, 3'b100); // Borrow
		add_row(16'h5E32, 4'h3, 8'hC4, 3'b010);
		add_row(16'h5E23, 4'h2, 8'h00, 3'b000);
		add_row(16'h5E02, 4'h0, 8'h00, 3'b011); // R0 still reads zero
		add_row(16'h5F04, 4'h4, 8'h60, 3'b100);
		add_row(16'h4781, 4'h7, 8'h81, 3'b100);
		add_row(16'h5F07, 4'h7, 8'h40, 3'b110);
		add_row(16'h5F17, 4'h7, 8'hA0, 3'b100); // Carry shifted in from the top
		add_row(16'h5F27, 4'h7, 8'h40, 3'b110);
		add_row(16'h5F37, 4'h7, 8'h81, 3'b100);
		add_row(16'h5F37, 4'h7, 8'h02, 3'b110);
		add_row(16'h5F47, 4'h7, 8'h01, 3'b110);
		add_row(16'h5F07, 4'h7, 8'h00, 3'b111);
		add_row(16'h4109, 4'h1, 8'h09, 3'b111);
		add_row(16'h5F99, 4'h9, 8'h09, 3'b011); // R1 against nibble
		add_row(16'h5F9A, 4'hA, 8'h09, 3'b000);
		add_row(16'h5F54, 4'h4, 8'hC0, 3'b100);
		add_row(16'h5044, 4'h4, 8'h80, 3'b110);
	endtask

	always @(negedge clk) begin
		res_ready = ($urandom % 4) != 0; // Stall about one cycle in four
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycles++;
			if (cycles > limit) begin
				abort_run($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
					cycles, out_idx, tbl.size()));
			end
		end
	end

	// Output side, sampled on the rising edge
	always @(posedge clk) begin
		if (rst_n) begin
			if (stalled) begin
				check_flag(res_valid, 1'b1, "res_valid while stalled");
				check_flag(res_write, hold_write, "res_write while stalled");
				check_reg(res_reg, hold_reg, "res_reg while stalled");
				check_data(res_data, hold_data, "res_data while stalled");
				check_flag(res_c, hold_c, "res_c while stalled");
				check_flag(res_z, hold_z, "res_z while stalled");
			end
			stalled = res_valid && !res_ready;
			hold_write = res_write;
			hold_reg = res_reg;
			hold_data = res_data;
			hold_c = res_c;
			hold_z = res_z;
			if (res_valid && res_ready) begin
				if (out_idx >= tbl.size()) begin
					abort_run("An extra result came out after the last instruction");
				end else begin
					check_result(tbl[out_idx], out_idx);
					out_idx++;
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		void'($urandom(32'hadac47e8));
		build_table();
		limit = tbl.size() * ROW_CYCLES;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < tbl.size(); i++) begin
			while (($urandom % 4) == 0) begin
				@(negedge clk);
			end
			in_valid = 1'b1;
			in_instr = tbl[i].word;
			@(posedge clk);
			while (!in_ready) begin
				@(posedge clk);
			end
			@(negedge clk);
			in_valid = 1'b0;
		end
		while (out_idx < tbl.size()) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk); // Room for a stray extra result
		if (out_idx == tbl.size() && !res_valid) begin
			$display("all tests passed");
			$finish;
		end else begin
			abort_run("Output still valid after all results were taken");
		end
	end

endmodule

// File: build.f
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/issue_stage.sv
verilog/alu_unit.sv
verilog/shift_unit.sv
verilog/writeback.sv
verilog/exec_top.sv
sim/tb_exec.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_exec \
	-f build.f -o sim_exec
./obj_dir/sim_exec > sim.log 2>&1 || true
cat sim.log
if grep -q "tests failed" sim.log; then
	exit 1
fi
grep -q "all tests passed" sim.log
